// File: Bender.yml
package:
  name: rasterix

sources:
  - src/rasterixPkg.sv
  - src/commandParser.sv
  - src/registerBank.sv
  - src/edgeRasterizer.sv
  - src/frameBuffer.sv
  - src/rasterixTop.sv
  - target: simulation
    files:
      - sim/rasterixTb.sv

// File: sim/rasterixTb.sv
/*
 * Testbench for rasterixTop. A 256-pixel reference image is kept here and every
 * accepted frame beat is checked against it by concurrent assertions.
 * Stimulus only uses boxes whose start lies at or before their end on both axes.
 */
`timescale 1ns/1ps

module rasterixTb;
    import rasterixPkg::*;

    localparam int ClockPeriod   = 8;
    localparam int ResetCycles   = 8;
    localparam int RandomSeed    = 9529;
    localparam int CmdTimeout    = 2000;
    localparam int StreamTimeout = 5000;

    logic        aclk;
    logic        rstN;
    logic        cmdValid;
    logic        cmdReady;
    logic [31:0] cmdData;
    logic        fbValid;
    logic        fbReady;
    logic        fbLast;
    logic [15:0] fbData;

    // Reference image and the parameter values last sent
    logic [ColorWidth-1:0] model [FrameSize];
    logic [ParamWidth-1:0] shadow [NumParams];

    logic [15:0] heldData;
    logic        heldLast;
    int          seed;
    int          beatIndex;
    int          errorCount;
    int          testErrors;
    int          testsRun;
    int          testsFailed;
    bit          anyWordSent;
    bit          commitSent;

    rasterixTop UUT (
        .aclk     (aclk),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .cmdData  (cmdData),
        .fbValid  (fbValid),
        .fbReady  (fbReady),
        .fbLast   (fbLast),
        .fbData   (fbData)
    );

    always #(ClockPeriod / 2) aclk = ~aclk;

    // Position of the next beat within the frame
    always @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            beatIndex <= 0;
        end else if (fbValid && fbReady) begin
            beatIndex <= fbLast ? 0 : beatIndex + 1;
        end
    end

    always @(posedge aclk) begin
        heldData <= fbData;
        heldLast <= fbLast;
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////
    readyAfterReset: assert property (@(posedge aclk) disable iff (!rstN)
        !anyWordSent |-> cmdReady)
    else begin
        $display("[FAIL] cmdReady = 0x%h before the first command, expected 0x1",
                 $sampled(cmdReady));
        errorCount++;
    end

    quietBeforeCommit: assert property (@(posedge aclk) disable iff (!rstN)
        !commitSent |-> !fbValid && !fbLast)
    else begin
        $display("[FAIL] fbValid = 0x%h fbLast = 0x%h before the first commit, expected 0x0",
                 $sampled(fbValid), $sampled(fbLast));
        errorCount++;
    end

    beatMatchesModel: assert property (@(posedge aclk) disable iff (!rstN)
        (fbValid && fbReady) |-> fbData == model[beatIndex])
    else begin
        $display("[FAIL] fbData = 0x%h at beat %0d, expected 0x%h",
                 $sampled(fbData), $sampled(beatIndex), model[$sampled(beatIndex)]);
        errorCount++;
    end

    lastOnFinalBeat: assert property (@(posedge aclk) disable iff (!rstN)
        (fbValid && fbReady) |-> fbLast == (beatIndex == FrameSize - 1))
    else begin
        $display("[FAIL] fbLast = 0x%h at beat %0d, expected 0x%h", $sampled(fbLast),
                 $sampled(beatIndex), ($sampled(beatIndex) == FrameSize - 1));
        errorCount++;
    end

    heldWhileStalled: assert property (@(posedge aclk) disable iff (!rstN)
        (fbValid && !fbReady) |=> fbValid && fbData == heldData && fbLast == heldLast)
    else begin
        $display("[FAIL] fbData = 0x%h fbLast = 0x%h after a stall, expected 0x%h 0x%h",
                 $sampled(fbData), $sampled(fbLast), $sampled(heldData), $sampled(heldLast));
        errorCount++;
    end

    // Parser must block further commands while a frame streams
    busyDuringStream: assert property (@(posedge aclk) disable iff (!rstN)
        fbValid |-> !cmdReady)
    else begin
        $display("[FAIL] cmdReady = 0x%h while the frame streams, expected 0x0",
                 $sampled(cmdReady));
        errorCount++;
    end

    //////////////////////////////////////////////////
    // Command helpers
    //////////////////////////////////////////////////
    function automatic logic [31:0] makeHeader(cmdOpcode_t op, paramIndex_t idx,
                                               logic [15:0] payload);
        cmdHeader_t header;
        header.opcode  = op;
        header.index   = idx;
        header.spare   = '0;
        header.payload = payload;
        return header;
    endfunction

    function automatic logic [31:0] boxCorner(int x, int y);
        return (32'(y) << 16) | 32'(x);
    endfunction

    task automatic finishRun();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 testsRun, testsRun - testsFailed, testsFailed, errorCount);
        if (errorCount == 0 && testsFailed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic sendWord(input logic [31:0] word);
        int waitCycles;
        waitCycles = 0;
        cmdValid <= 1'b1;
        cmdData  <= word;
        @(posedge aclk);
        while (!cmdReady && waitCycles < CmdTimeout) begin
            waitCycles++;
            @(posedge aclk);
        end
        if (!cmdReady) begin
            $display("Timeout: command word 0x%h not accepted within %0d cycles",
                     word, CmdTimeout);
            errorCount++;
            finishRun();
        end else begin
            anyWordSent = 1'b1;
        end
    endtask

    task automatic setParam(input paramIndex_t idx, input logic [31:0] value);
        shadow[idx] = value;
        sendWord(makeHeader(opSetReg, idx, 16'h0000));
        sendWord(value);
    endtask

    // Edge values from start plus dx times incX plus dy times incY
    task automatic modelRender();
        int sx;
        int sy;
        int ex;
        int ey;
        int w [3];
        bit covered;
        sx = shadow[bbStart][3:0];
        sy = shadow[bbStart][19:16];
        ex = shadow[bbEnd][3:0];
        ey = shadow[bbEnd][19:16];
        for (int y = sy; y <= ey; y++) begin
            for (int x = sx; x <= ex; x++) begin
                covered = 1'b1;
                for (int i = 0; i < 3; i++) begin
                    w[i] = int'(shadow[w0 + i]) + (x - sx) * int'(shadow[w0IncX + i])
                         + (y - sy) * int'(shadow[w0IncY + i]);
                    if (w[i] < 0) begin
                        covered = 1'b0;
                    end
                end
                if (covered) begin
                    model[y * XResolution + x] = shadow[triColor][ColorWidth-1:0];
                end
            end
        end
    endtask

    task automatic renderTriangle();
        modelRender();
        sendWord(makeHeader(opRender, bbStart, 16'h0000));
    endtask

    task automatic clearFrame(input logic [15:0] color);
        for (int i = 0; i < FrameSize; i++) begin
            model[i] = color;
        end
        sendWord(makeHeader(opClear, bbStart, color));
    endtask

    // Counts accepted beats until the one marked last
    task automatic collectFrame(input bit randomReady);
        int beatCount;
        int waitCycles;
        int rnd;
        bit lastSeen;
        beatCount  = 0;
        waitCycles = 0;
        lastSeen   = 1'b0;
        while (!lastSeen && waitCycles < StreamTimeout) begin
            rnd = $random(seed);
            fbReady <= randomReady ? rnd[0] : 1'b1;
            @(posedge aclk);
            waitCycles++;
            if (fbValid && fbReady) begin
                beatCount++;
                lastSeen = fbLast;
            end
        end
        fbReady <= 1'b1;
        if (!lastSeen) begin
            $display("Timeout: no final frame beat within %0d cycles", StreamTimeout);
            errorCount++;
            finishRun();
        end else if (beatCount != FrameSize) begin
            $display("Frame stream ended after %0d beats instead of %0d",
                     beatCount, FrameSize);
            errorCount++;
        end
    endtask

    task automatic commitFrame(input bit randomReady);
        sendWord(makeHeader(opCommit, bbStart, 16'h0000));
        commitSent = 1'b1;
        cmdValid <= 1'b0;
        collectFrame(randomReady);
    endtask

    task automatic beginTest();
        testErrors = errorCount;
    endtask

    task automatic endTest(input string name);
        cmdValid <= 1'b0;
        repeat (2) @(posedge aclk);
        testsRun++;
        if (errorCount == testErrors) begin
            $display("Test %0d %s: ok", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testsRun, name, errorCount - testErrors);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        aclk        = 1'b0;
        rstN        = 1'b0;
        cmdValid    <= 1'b0;
        cmdData     <= '0;
        fbReady     <= 1'b1;
        seed        = RandomSeed;
        errorCount  = 0;
        testErrors  = 0;
        testsRun    = 0;
        testsFailed = 0;
        anyWordSent = 1'b0;
        commitSent  = 1'b0;
        for (int i = 0; i < FrameSize; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < NumParams; i++) begin
            shadow[i] = '0;
        end
        repeat (ResetCycles) @(posedge aclk);
        rstN <= 1'b1;

        beginTest();
        repeat (16) @(posedge aclk);
        endTest("reset state");

        beginTest();
        clearFrame(16'h001F);
        commitFrame(1'b0);
        endTest("clear and commit");

        // Triangle cutting through the box, some box pixels stay clear
        beginTest();
        setParam(bbStart, boxCorner(2, 2));
        setParam(bbEnd, boxCorner(13, 13));
        setParam(w0, 0);
        setParam(w0IncX, 1);
        setParam(w0IncY, -1);
        setParam(w1, 10);
        setParam(w1IncX, -1);
        setParam(w1IncY, 0);
        setParam(w2, -1);
        setParam(w2IncX, 0);
        setParam(w2IncY, 1);
        setParam(triColor, 32'h0000_F800);
        renderTriangle();
        commitFrame(1'b0);
        endTest("triangle render");

        // Fully covered box smaller than the screen
        beginTest();
        clearFrame(16'h07E0);
        setParam(bbStart, boxCorner(4, 5));
        setParam(bbEnd, boxCorner(9, 10));
        setParam(w0, 0);
        setParam(w1, 2);
        setParam(w2, 5);
        setParam(w0IncX, 1);
        setParam(w1IncX, 2);
        setParam(w2IncX, 3);
        setParam(w0IncY, 1);
        setParam(w1IncY, 1);
        setParam(w2IncY, 2);
        setParam(triColor, 32'h0000_FFFF);
        renderTriangle();
        commitFrame(1'b0);
        endTest("box render");

        beginTest();
        commitFrame(1'b1);
        endTest("commit with stalls");

        // No idle cycles between these commands
        beginTest();
        clearFrame(16'h4208);
        setParam(bbStart, boxCorner(0, 0));
        setParam(bbEnd, boxCorner(15, 15));
        setParam(w0, -6);
        setParam(w0IncX, 1);
        setParam(w0IncY, 1);
        setParam(w1, 20);
        setParam(w1IncX, -1);
        setParam(w1IncY, -1);
        setParam(w2, 12);
        setParam(w2IncX, 0);
        setParam(w2IncY, -1);
        setParam(triColor, 32'h0000_001F);
        renderTriangle();
        setParam(triColor, 32'h0000_F81F);
        setParam(bbEnd, boxCorner(7, 7));
        renderTriangle();
        commitFrame(1'b1);
        endTest("back to back commands");

        repeat (4) @(posedge aclk);
        finishRun();
    end

endmodule

// File: src.f
src/rasterixPkg.sv
src/commandParser.sv
src/registerBank.sv
src/edgeRasterizer.sv
src/frameBuffer.sv
src/rasterixTop.sv
sim/rasterixTb.sv

// File: src/commandParser.sv
/*
 * Command stream decoder. One operation is outstanding at a time, and
 * cmdReady stays low until it finishes. Unknown opcodes are dropped.
 */
`timescale 1ns/1ps

module commandParser (
    input  logic                     aclk,
    input  logic                     rstN,

    input  logic                     cmdValid,
    output logic                     cmdReady,
    input  logic [31:0]              cmdData,

    output logic                     regWrite,
    output rasterixPkg::paramIndex_t regIndex,
    output logic [31:0]              regData,

    output logic                     startRendering,
    input  logic                     rasterizerRunning,

    output logic                     cmdClear,
    output logic                     cmdCommit,
    output logic [15:0]              clearColor,
    input  logic                     applied
);
    import rasterixPkg::*;

    parserState_t state;
    cmdHeader_t   header;
    logic         headerAccepted;

    assign header         = cmdHeader_t'(cmdData);
    assign cmdReady       = (state == psHeader) || (state == psRegValue);
    assign headerAccepted = cmdValid && (state == psHeader);

    // Value word goes straight to the bank
    assign regWrite = cmdValid && (state == psRegValue);
    assign regData  = cmdData;

    always_ff @(posedge aclk) begin
        if (headerAccepted) begin
            regIndex <= header.index;
            if (header.opcode == opClear) begin
                clearColor <= header.payload;
            end
        end
    end

    //////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state          <= psHeader;
            startRendering <= 1'b0;
            cmdClear       <= 1'b0;
            cmdCommit      <= 1'b0;
        end else begin
            startRendering <= 1'b0;
            cmdClear       <= 1'b0;
            cmdCommit      <= 1'b0;
            case (state)
                psHeader: begin
                    if (headerAccepted) begin
                        case (header.opcode)
                            opSetReg: state <= psRegValue;
                            opRender: begin
                                startRendering <= 1'b1;
                                state          <= psRenderStart;
                            end
                            opClear: begin
                                cmdClear <= 1'b1;
                                state    <= psWaitApplied;
                            end
                            opCommit: begin
                                cmdCommit <= 1'b1;
                                state     <= psWaitApplied;
                            end
                            default: state <= psHeader;
                        endcase
                    end
                end
                psRegValue: begin
                    if (cmdValid) begin
                        state <= psHeader;
                    end
                end
                // Rasterizer raises its running flag one cycle after the pulse
                psRenderStart: state <= psRenderRun;
                psRenderRun: begin
                    if (!rasterizerRunning) begin
                        state <= psRenderLand;
                    end
                end
                // Let the final registered fragment reach memory
                psRenderLand: state <= psHeader;
                psWaitApplied: begin
                    if (applied) begin
                        state <= psHeader;
                    end
                end
                default: state <= psHeader;
            endcase
        end
    end

    pulsesExclusive: assert property (@(posedge aclk) disable iff (!rstN)
        $onehot0({startRendering, cmdClear, cmdCommit}));

endmodule

// File: src/edgeRasterizer.sv
/*
 * Bounding box walker with incremental edge functions, one pixel per clock.
 * Params must stay stable while running. No back-pressure on fragments.
 * A box with end below start still ends after one pixel or row.
 */
`timescale 1ns/1ps

module edgeRasterizer (
    input  logic                         aclk,
    input  logic                         rstN,
    input  rasterixPkg::triangleParams_t params,
    input  logic                         startRendering,
    output logic                         rasterizerRunning,
    output logic                         fragValid,
    output rasterixPkg::fragment_t       frag
);
    import rasterixPkg::*;

    rasterState_t state;

    logic [3:0] x;
    logic [3:0] y;
    logic [3:0] startX;
    logic [3:0] startY;
    logic [3:0] endX;
    logic [3:0] endY;

    logic signed [ParamWidth-1:0] wStart [3];
    logic signed [ParamWidth-1:0] incX   [3];
    logic signed [ParamWidth-1:0] incY   [3];
    logic signed [ParamWidth-1:0] curW   [3];
    logic signed [ParamWidth-1:0] rowW   [3];

    logic covered;
    logic rowEnd;
    logic boxEnd;

    assign startX = params.bbStart[3:0];
    assign startY = params.bbStart[19:16];
    assign endX   = params.bbEnd[3:0];
    assign endY   = params.bbEnd[19:16];

    assign wStart = '{params.w0, params.w1, params.w2};
    assign incX   = '{params.w0IncX, params.w1IncX, params.w2IncX};
    assign incY   = '{params.w0IncY, params.w1IncY, params.w2IncY};

    // Inside when no edge value is negative
    assign covered = !curW[0][ParamWidth-1] && !curW[1][ParamWidth-1]
                  && !curW[2][ParamWidth-1];
    assign rowEnd  = x >= endX;
    assign boxEnd  = rowEnd && (y >= endY);

    assign rasterizerRunning = state == rsRun;

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state     <= rsIdle;
            fragValid <= 1'b0;
        end else begin
            fragValid <= (state == rsRun) && covered;
            case (state)
                rsIdle: begin
                    if (startRendering) begin
                        state <= rsRun;
                    end
                end
                rsRun: begin
                    if (boxEnd) begin
                        state <= rsIdle;
                    end
                end
                default: state <= rsIdle;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Walk datapath
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        frag.index <= IndexWidth'(int'(y) * XResolution + int'(x));
        frag.color <= params.triColor[ColorWidth-1:0];
        if (state == rsIdle) begin
            // Preload the box origin until the start pulse arrives
            x    <= startX;
            y    <= startY;
            curW <= wStart;
            rowW <= wStart;
        end else if (rowEnd) begin
            x <= startX;
            y <= y + 4'd1;
            for (int i = 0; i < 3; i++) begin
                rowW[i] <= rowW[i] + incY[i];
                curW[i] <= rowW[i] + incY[i];
            end
        end else begin
            x <= x + 4'd1;
            for (int i = 0; i < 3; i++) begin
                curW[i] <= curW[i] + incX[i];
            end
        end
    end

    fragInsideBox: assert property (@(posedge aclk) disable iff (!rstN)
        fragValid |-> (frag.index[3:0] >= startX) && (frag.index[3:0] <= endX)
                   && (frag.index[7:4] >= startY) && (frag.index[7:4] <= endY));

endmodule

// File: src/frameBuffer.sv
/*
 * Colour memory with fragment writes, a clear engine and a commit stream.
 * Clear and commit must not overlap fragment traffic.
 * applied pulses once when either operation is finished.
 */
`timescale 1ns/1ps

module frameBuffer (
    input  logic                   aclk,
    input  logic                   rstN,

    input  logic                   fragValid,
    input  rasterixPkg::fragment_t frag,

    input  logic                   cmdClear,
    input  logic                   cmdCommit,
    input  logic [15:0]            clearColor,
    output logic                   applied,

    output logic                   fbValid,
    input  logic                   fbReady,
    output logic                   fbLast,
    output logic [15:0]            fbData
);
    import rasterixPkg::*;

    fbState_t state;

    logic [ColorWidth-1:0] mem [FrameSize];
    logic [IndexWidth-1:0] addr;
    logic [ColorWidth-1:0] readData;
    logic                  clearEn;
    logic                  readEn;

    assign clearEn = state == fbClear;
    // Fetch the next pixel when the output slot is empty or being taken
    assign readEn  = (state == fbStream) && !(fbValid && fbLast)
                  && (!fbValid || fbReady);
    assign fbData  = readData;

    //////////////////////////////////////////////////
    // Memory
    //////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (fragValid) begin
            mem[frag.index] <= frag.color;
        end else if (clearEn) begin
            mem[addr] <= clearColor;
        end
        // Read register doubles as the stall hold register
        if (readEn) begin
            readData <= mem[addr];
        end
    end

    //////////////////////////////////////////////////
    // Clear and commit control
    //////////////////////////////////////////////////
    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            state   <= fbIdle;
            addr    <= '0;
            applied <= 1'b0;
            fbValid <= 1'b0;
            fbLast  <= 1'b0;
        end else begin
            applied <= 1'b0;
            case (state)
                fbIdle: begin
                    addr <= '0;
                    if (cmdClear) begin
                        state <= fbClear;
                    end else if (cmdCommit) begin
                        state <= fbStream;
                    end
                end
                fbClear: begin
                    addr <= addr + 1'b1;
                    if (addr == IndexWidth'(FrameSize - 1)) begin
                        state   <= fbIdle;
                        applied <= 1'b1;
                    end
                end
                fbStream: begin
                    if (fbValid && fbReady && fbLast) begin
                        fbValid <= 1'b0;
                        fbLast  <= 1'b0;
                        applied <= 1'b1;
                        state   <= fbIdle;
                    end else if (readEn) begin
                        fbValid <= 1'b1;
                        fbLast  <= addr == IndexWidth'(FrameSize - 1);
                        addr    <= addr + 1'b1;
                    end
                end
                default: state <= fbIdle;
            endcase
        end
    end

    streamHeldOnStall: assert property (@(posedge aclk) disable iff (!rstN)
        (fbValid && !fbReady) |=> $stable(fbData) && $stable(fbLast));

endmodule

// File: src/rasterixPkg.sv
/*
 * Shared types and constants for the rasterizer core.
 * Screen is fixed at 16x16 RGB565; coordinates are 4 bits wide.
 * Triangle registers are laid out so slot N sits at bits N*32 of the struct.
 */
package rasterixPkg;

    //////////////////////////////////////////////////
    // Screen and register geometry
    //////////////////////////////////////////////////
    localparam int XResolution = 16;
    localparam int YResolution = 16;
    localparam int FrameSize   = XResolution * YResolution;
    localparam int IndexWidth  = $clog2(FrameSize);
    localparam int ParamWidth  = 32;
    localparam int ColorWidth  = 16;
    // One slot per paramIndex_t entry
    localparam int NumParams   = 12;

    typedef enum logic [3:0] {
        opSetReg = 4'd0,
        opRender = 4'd1,
        opClear  = 4'd2,
        opCommit = 4'd3
    } cmdOpcode_t;

    // Bounding box words carry x in 3:0 and y in 19:16
    typedef enum logic [3:0] {
        bbStart  = 4'd0,
        bbEnd    = 4'd1,
        w0       = 4'd2,
        w1       = 4'd3,
        w2       = 4'd4,
        w0IncX   = 4'd5,
        w1IncX   = 4'd6,
        w2IncX   = 4'd7,
        w0IncY   = 4'd8,
        w1IncY   = 4'd9,
        w2IncY   = 4'd10,
        triColor = 4'd11
    } paramIndex_t;

    typedef struct packed {
        cmdOpcode_t  opcode;
        paramIndex_t index;
        logic [7:0]  spare;
        logic [15:0] payload;
    } cmdHeader_t;

    // Highest slot first, so a flat register vector casts straight onto it
    typedef struct packed {
        logic [ParamWidth-1:0] triColor;
        logic [ParamWidth-1:0] w2IncY;
        logic [ParamWidth-1:0] w1IncY;
        logic [ParamWidth-1:0] w0IncY;
        logic [ParamWidth-1:0] w2IncX;
        logic [ParamWidth-1:0] w1IncX;
        logic [ParamWidth-1:0] w0IncX;
        logic [ParamWidth-1:0] w2;
        logic [ParamWidth-1:0] w1;
        logic [ParamWidth-1:0] w0;
        logic [ParamWidth-1:0] bbEnd;
        logic [ParamWidth-1:0] bbStart;
    } triangleParams_t;

    typedef struct packed {
        logic [IndexWidth-1:0] index;
        logic [ColorWidth-1:0] color;
    } fragment_t;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        psHeader,
        psRegValue,
        psRenderStart,
        psRenderRun,
        psRenderLand,
        psWaitApplied
    } parserState_t;

    typedef enum logic {
        rsIdle,
        rsRun
    } rasterState_t;

    typedef enum logic [1:0] {
        fbIdle,
        fbClear,
        fbStream
    } fbState_t;

endpackage

// File: src/rasterixTop.sv
/*
 * Top of the rasterizer core. 32-bit command stream in, RGB565 frame stream out.
 */
`timescale 1ns/1ps

module rasterixTop (
    input  logic        aclk,
    input  logic        rstN,

    input  logic        cmdValid,
    output logic        cmdReady,
    input  logic [31:0] cmdData,

    output logic        fbValid,
    input  logic        fbReady,
    output logic        fbLast,
    output logic [15:0] fbData
);
    import rasterixPkg::*;

    // Parser to register bank
    logic            regWrite;
    paramIndex_t     regIndex;
    logic [31:0]     regData;
    triangleParams_t params;

    // Render control and fragments
    logic            startRendering;
    logic            rasterizerRunning;
    logic            fragValid;
    fragment_t       frag;

    // Framebuffer operations
    logic            cmdClear;
    logic            cmdCommit;
    logic [15:0]     clearColor;
    logic            applied;

    commandParser parser (
        .aclk              (aclk),
        .rstN              (rstN),
        .cmdValid          (cmdValid),
        .cmdReady          (cmdReady),
        .cmdData           (cmdData),
        .regWrite          (regWrite),
        .regIndex          (regIndex),
        .regData           (regData),
        .startRendering    (startRendering),
        .rasterizerRunning (rasterizerRunning),
        .cmdClear          (cmdClear),
        .cmdCommit         (cmdCommit),
        .clearColor        (clearColor),
        .applied           (applied)
    );

    registerBank regBank (
        .aclk     (aclk),
        .rstN     (rstN),
        .regWrite (regWrite),
        .regIndex (regIndex),
        .regData  (regData),
        .params   (params)
    );

    edgeRasterizer rasterizer (
        .aclk              (aclk),
        .rstN              (rstN),
        .params            (params),
        .startRendering    (startRendering),
        .rasterizerRunning (rasterizerRunning),
        .fragValid         (fragValid),
        .frag              (frag)
    );

    frameBuffer colorBuffer (
        .aclk       (aclk),
        .rstN       (rstN),
        .fragValid  (fragValid),
        .frag       (frag),
        .cmdClear   (cmdClear),
        .cmdCommit  (cmdCommit),
        .clearColor (clearColor),
        .applied    (applied),
        .fbValid    (fbValid),
        .fbReady    (fbReady),
        .fbLast     (fbLast),
        .fbData     (fbData)
    );

endmodule

// File: src/registerBank.sv
/*
 * Triangle parameter registers. A write shows on params one cycle later.
 * Indices past the last slot are ignored.
 */
`timescale 1ns/1ps

module registerBank (
    input  logic                         aclk,
    input  logic                         rstN,
    input  logic                         regWrite,
    input  rasterixPkg::paramIndex_t     regIndex,
    input  logic [31:0]                  regData,
    output rasterixPkg::triangleParams_t params
);
    import rasterixPkg::*;

    logic [NumParams-1:0][ParamWidth-1:0] regs;

    always_ff @(posedge aclk or negedge rstN) begin
        if (!rstN) begin
            regs <= '0;
        end else if (regWrite && (regIndex < NumParams)) begin
            regs[regIndex] <= regData;
        end
    end

    // Slot order matches the struct field order
    assign params = triangleParams_t'(regs);

    writeIndexInRange: assert property (@(posedge aclk) disable iff (!rstN)
        regWrite |-> (regIndex < NumParams));

endmodule
